//--- rtl/mmu_pkg.sv
/*
 * shared definitions of the Sv32 translation unit
 *   privilege codes and access kinds
 *   PTE bit positions and field widths
 *   page-fault causes and the satp mode bit
 *   vaddr_u, a virtual address seen as a 4 KiB page or a 4 MiB megapage
 */
package mmu_pkg;

    // privilege levels
    localparam logic [1:0] PRIV_U = 2'd0;
    localparam logic [1:0] PRIV_S = 2'd1;
    localparam logic [1:0] PRIV_M = 2'd3;

    // access kinds, each one the index of its permission bit in xwr
    localparam logic [1:0] ACC_READ  = 2'd0;
    localparam logic [1:0] ACC_WRITE = 2'd1;
    localparam logic [1:0] ACC_CODE  = 2'd2;

    // PTE flags
    localparam int PTE_V = 0;
    localparam int PTE_R = 1;
    localparam int PTE_W = 2;
    localparam int PTE_X = 3;
    localparam int PTE_U = 4;
    localparam int PTE_A = 6;
    localparam int PTE_D = 7;
    // lowest bit of the PPN field
    localparam int PTE_PPN = 10;

    localparam int PAGE_OFS_W = 12;
    localparam int VPN_W      = 10;
    localparam int PPN_W      = 20;

    localparam logic [3:0] CAUSE_FETCH_PF = 4'd12;
    localparam logic [3:0] CAUSE_LOAD_PF  = 4'd13;
    localparam logic [3:0] CAUSE_STORE_PF = 4'd15;

    localparam int SATP_MODE_BIT = 31;

    typedef union packed {
        struct packed {
            logic [VPN_W-1:0]      vpn1;
            logic [VPN_W-1:0]      vpn0;
            logic [PAGE_OFS_W-1:0] ofs;
        } page;
        struct packed {
            logic [VPN_W-1:0]            vpn1;
            logic [VPN_W+PAGE_OFS_W-1:0] ofs;
        } mega;
    } vaddr_u;

endpackage

//--- rtl/tlb.sv
/*
 * direct-mapped TLB
 *   combinational lookup on the held VPN
 *   tag and PPN written at the index, valid bits cleared by flush
 */
`timescale 1ns/1ns

module tlb #(
    parameter int ENTRIES = 4
) (
    input  logic                        CLK,
    input  logic                        i_arst_n,
    input  logic                        i_flush,
    input  logic                        i_we,
    input  logic [2*mmu_pkg::VPN_W-1:0] i_vpn,
    input  logic [mmu_pkg::PPN_W-1:0]   i_wppn,
    output logic                        o_hit,
    output logic [mmu_pkg::PPN_W-1:0]   o_ppn
);
    import mmu_pkg::*;

    localparam int IDX_W = $clog2(ENTRIES);
    localparam int TAG_W = 2*VPN_W - IDX_W;

    logic [ENTRIES-1:0] r_valid;
    logic [TAG_W-1:0]   r_tag [ENTRIES];
    logic [PPN_W-1:0]   r_ppn [ENTRIES];

    logic [IDX_W-1:0]   idx;
    logic [TAG_W-1:0]   tag;

    // low VPN bits select the entry
    assign idx = i_vpn[IDX_W-1:0];
    assign tag = i_vpn[2*VPN_W-1:IDX_W];

    assign o_hit = r_valid[idx] && (r_tag[idx] == tag);
    assign o_ppn = r_ppn[idx];

    // flush beats a fill in the same cycle
    always_ff @(posedge CLK or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_valid <= '0;
        end else if (i_flush) begin
            r_valid <= '0;
        end else if (i_we) begin
            r_valid[idx] <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (i_we) begin
            r_tag[idx] <= tag;
            r_ppn[idx] <= i_wppn;
        end
    end

endmodule

//--- rtl/pte_check.sv
/*
 * leaf PTE check
 *   valid, leaf and reserved-encoding tests
 *   U/SUM and MXR permission rules per access kind
 *   physical address for page and megapage, A/D update word
 */
`timescale 1ns/1ns

module pte_check (
    input  logic [31:0]     i_pte,
    input  logic            i_level,
    input  mmu_pkg::vaddr_u i_vaddr,
    input  logic [1:0]      i_acc,
    input  logic [1:0]      i_priv,
    input  logic            i_sum,
    input  logic            i_mxr,
    output logic            o_leaf,
    output logic            o_fault,
    output logic [31:0]     o_paddr,
    output logic            o_need_wb,
    output logic [31:0]     o_pte_wb
);
    import mmu_pkg::*;

    logic [2:0] xwr;
    logic [2:0] xwr_eff;
    logic       is_store;
    logic       bad_enc;
    logic       bad_user;
    logic       bad_perm;

    // bit i of xwr is the permission for access kind i
    assign xwr      = {i_pte[PTE_X], i_pte[PTE_W], i_pte[PTE_R]};
    // MXR makes executable pages readable
    assign xwr_eff  = {xwr[2], xwr[1], xwr[0] | (i_mxr & xwr[2])};
    assign is_store = (i_acc == ACC_WRITE);

    assign o_leaf = |xwr;

    // W without R is reserved
    assign bad_enc  = xwr[1] && !xwr[0];
    assign bad_user = (i_priv == PRIV_S && i_pte[PTE_U] && !i_sum) ||
                      (i_priv == PRIV_U && !i_pte[PTE_U]);
    assign bad_perm = (i_acc == 2'd3) || !xwr_eff[i_acc];

    // a pointer at level 0 has nowhere left to go
    assign o_fault = !i_pte[PTE_V] ||
                     (o_leaf ? (bad_enc || bad_user || bad_perm) : !i_level);

    assign o_paddr = i_level ? {i_pte[PTE_PPN+VPN_W +: VPN_W], i_vaddr.mega.ofs}
                             : {i_pte[PTE_PPN +: PPN_W], i_vaddr.page.ofs};

    assign o_need_wb = !i_pte[PTE_A] || (is_store && !i_pte[PTE_D]);

    always_comb begin
        o_pte_wb        = i_pte;
        o_pte_wb[PTE_A] = 1'b1;
        if (is_store) begin
            o_pte_wb[PTE_D] = 1'b1;
        end
    end

endmodule

//--- rtl/walk_fsm.sv
/*
 * translation FSM
 *   request capture and bare-mode bypass
 *   TLB hit response, two-level page walk over the memory port
 *   A/D write-back and TLB fill
 */
`timescale 1ns/1ns

module walk_fsm (
    input  logic                      CLK,
    input  logic                      i_arst_n,
    input  logic                      i_req_valid,
    output logic                      o_req_ready,
    input  logic [31:0]               i_req_vaddr,
    input  logic [1:0]                i_req_acc,
    input  logic [1:0]                i_priv,
    input  logic [31:0]               i_satp,
    input  logic                      i_sum,
    input  logic                      i_mxr,
    output logic                      o_rsp_valid,
    input  logic                      i_rsp_ready,
    output logic [31:0]               o_rsp_paddr,
    output logic                      o_rsp_fault,
    output logic [3:0]                o_rsp_cause,
    output logic                      o_mem_valid,
    input  logic                      i_mem_ready,
    output logic                      o_mem_we,
    output logic [31:0]               o_mem_addr,
    output logic [31:0]               o_mem_wdata,
    input  logic                      i_mem_rvalid,
    input  logic [31:0]               i_mem_rdata,
    input  logic                      i_code_hit,
    input  logic [mmu_pkg::PPN_W-1:0] i_code_ppn,
    input  logic                      i_read_hit,
    input  logic [mmu_pkg::PPN_W-1:0] i_read_ppn,
    input  logic                      i_write_hit,
    input  logic [mmu_pkg::PPN_W-1:0] i_write_ppn,
    input  logic                      i_chk_leaf,
    input  logic                      i_chk_fault,
    input  logic [31:0]               i_chk_paddr,
    input  logic                      i_chk_need_wb,
    input  logic [31:0]               i_chk_pte_wb,
    output mmu_pkg::vaddr_u           o_vaddr,
    output logic [1:0]                o_acc,
    output logic [1:0]                o_priv,
    output logic                      o_sum,
    output logic                      o_mxr,
    output logic [31:0]               o_pte,
    output logic                      o_level,
    output logic                      o_code_we,
    output logic                      o_read_we,
    output logic                      o_write_we,
    output logic [mmu_pkg::PPN_W-1:0] o_tlb_wppn
);
    import mmu_pkg::*;

    localparam logic [2:0] IDLE      = 3'd0;
    localparam logic [2:0] LOOKUP    = 3'd1;
    localparam logic [2:0] READ_L1   = 3'd2;
    localparam logic [2:0] WAIT_L1   = 3'd3;
    localparam logic [2:0] READ_L0   = 3'd4;
    localparam logic [2:0] WAIT_L0   = 3'd5;
    localparam logic [2:0] WRITE_PTE = 3'd6;
    localparam logic [2:0] RESPOND   = 3'd7;

    logic [2:0]       r_state;
    logic             r_level;
    logic             r_fault;
    vaddr_u           r_vaddr;
    logic [1:0]       r_acc;
    logic [1:0]       r_priv;
    logic             r_sum;
    logic             r_mxr;
    logic [31:0]      r_paddr;
    logic [31:0]      r_pte;
    logic [31:0]      r_pte_addr;

    vaddr_u           req_va;
    logic             bare;
    logic             sel_hit;
    logic [PPN_W-1:0] sel_ppn;
    logic             rd_cmd;
    logic             rd_wait;
    logic             pte_in;
    logic             tlb_fill;

    assign req_va = i_req_vaddr;
    assign bare   = (i_priv == PRIV_M) || !i_satp[SATP_MODE_BIT];

    // hit from the TLB of the held access kind
    always_comb begin
        case (r_acc)
            ACC_CODE: begin
                sel_hit = i_code_hit;
                sel_ppn = i_code_ppn;
            end
            ACC_READ: begin
                sel_hit = i_read_hit;
                sel_ppn = i_read_ppn;
            end
            default: begin
                sel_hit = i_write_hit;
                sel_ppn = i_write_ppn;
            end
        endcase
    end

    assign rd_cmd  = (r_state == READ_L1) || (r_state == READ_L0);
    assign rd_wait = (r_state == WAIT_L1) || (r_state == WAIT_L0);
    // read data may come back in the cycle the command is taken
    assign pte_in  = i_mem_rvalid && ((rd_cmd && i_mem_ready) || rd_wait);

    // checker looks at the PTE on the bus while a read is open
    assign o_pte   = (rd_cmd || rd_wait) ? i_mem_rdata : r_pte;
    assign o_level = r_level;
    assign o_vaddr = r_vaddr;
    assign o_acc   = r_acc;
    assign o_priv  = r_priv;
    assign o_sum   = r_sum;
    assign o_mxr   = r_mxr;

    assign tlb_fill   = (pte_in && i_chk_leaf && !i_chk_fault && !i_chk_need_wb) ||
                        (r_state == WRITE_PTE && i_mem_ready);
    assign o_tlb_wppn = i_chk_paddr[31:PAGE_OFS_W];
    assign o_code_we  = tlb_fill && (r_acc == ACC_CODE);
    assign o_read_we  = tlb_fill && (r_acc == ACC_READ);
    assign o_write_we = tlb_fill && (r_acc == ACC_WRITE);

    assign o_req_ready = (r_state == IDLE);
    // a TLB hit answers straight from LOOKUP
    assign o_rsp_valid = (r_state == RESPOND) || (r_state == LOOKUP && sel_hit);
    assign o_rsp_paddr = (r_state == LOOKUP) ? {sel_ppn, r_vaddr.page.ofs} : r_paddr;
    assign o_rsp_fault = r_fault;
    assign o_rsp_cause = !r_fault              ? 4'd0 :
                         (r_acc == ACC_CODE)   ? CAUSE_FETCH_PF :
                         (r_acc == ACC_READ)   ? CAUSE_LOAD_PF  : CAUSE_STORE_PF;

    assign o_mem_valid = rd_cmd || (r_state == WRITE_PTE);
    assign o_mem_we    = (r_state == WRITE_PTE);
    assign o_mem_addr  = r_pte_addr;
    assign o_mem_wdata = i_chk_pte_wb;

    always_ff @(posedge CLK or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_state <= IDLE;
            r_level <= 1'b1;
            r_fault <= 1'b0;
        end else begin
            case (r_state)
                IDLE: begin
                    if (i_req_valid) begin
                        r_level <= 1'b1;
                        r_fault <= 1'b0;
                        r_state <= bare ? RESPOND : LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (!sel_hit) begin
                        r_state <= READ_L1;
                    end else if (i_rsp_ready) begin
                        r_state <= IDLE;
                    end else begin
                        r_state <= RESPOND;
                    end
                end
                READ_L1, WAIT_L1, READ_L0, WAIT_L0: begin
                    if (pte_in) begin
                        if (i_chk_fault) begin
                            r_fault <= 1'b1;
                            r_state <= RESPOND;
                        end else if (!i_chk_leaf) begin
                            r_level <= 1'b0;
                            r_state <= READ_L0;
                        end else begin
                            r_state <= i_chk_need_wb ? WRITE_PTE : RESPOND;
                        end
                    end else if (rd_cmd && i_mem_ready) begin
                        r_state <= r_level ? WAIT_L1 : WAIT_L0;
                    end
                end
                WRITE_PTE: begin
                    if (i_mem_ready) begin
                        r_state <= RESPOND;
                    end
                end
                default: begin
                    if (i_rsp_ready) begin
                        r_state <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (r_state == IDLE && i_req_valid) begin
            r_vaddr    <= req_va;
            r_acc      <= i_req_acc;
            r_priv     <= i_priv;
            r_sum      <= i_sum;
            r_mxr      <= i_mxr;
            r_paddr    <= i_req_vaddr;
            // level-1 entry at satp.PPN * 4096 + vpn1 * 4
            r_pte_addr <= {i_satp[PPN_W-1:0], req_va.page.vpn1, 2'b00};
        end
        if (r_state == LOOKUP) begin
            r_paddr <= {sel_ppn, r_vaddr.page.ofs};
        end
        if (pte_in) begin
            r_pte   <= i_mem_rdata;
            r_paddr <= i_chk_fault ? 32'd0 : i_chk_paddr;
            if (!i_chk_leaf) begin
                r_pte_addr <= {i_mem_rdata[PTE_PPN +: PPN_W], r_vaddr.page.vpn0, 2'b00};
            end
        end
    end

endmodule

//--- rtl/mmu_top.sv
/*
 * Sv32 address translation unit
 *   fetch, load and store TLBs
 *   leaf PTE checker and walk FSM on one memory port
 */
`timescale 1ns/1ns

module mmu_top #(
    parameter int TLB_ENTRIES = 4
) (
    input  logic        CLK,
    input  logic        i_arst_n,
    input  logic        i_req_valid,
    output logic        o_req_ready,
    input  logic [31:0] i_req_vaddr,
    input  logic [1:0]  i_req_acc,
    input  logic [1:0]  i_priv,
    input  logic [31:0] i_satp,
    input  logic        i_sum,
    input  logic        i_mxr,
    input  logic        i_flush,
    output logic        o_rsp_valid,
    input  logic        i_rsp_ready,
    output logic [31:0] o_rsp_paddr,
    output logic        o_rsp_fault,
    output logic [3:0]  o_rsp_cause,
    output logic        o_mem_valid,
    input  logic        i_mem_ready,
    output logic        o_mem_we,
    output logic [31:0] o_mem_addr,
    output logic [31:0] o_mem_wdata,
    input  logic        i_mem_rvalid,
    input  logic [31:0] i_mem_rdata
);
    import mmu_pkg::*;

    // held request
    vaddr_u           vaddr;
    logic [1:0]       acc;
    logic [1:0]       priv;
    logic             sum;
    logic             mxr;
    logic [31:0]      pte;
    logic             level;

    // TLB lookups and fills
    logic             code_hit;
    logic             read_hit;
    logic             write_hit;
    logic [PPN_W-1:0] code_ppn;
    logic [PPN_W-1:0] read_ppn;
    logic [PPN_W-1:0] write_ppn;
    logic             code_we;
    logic             read_we;
    logic             write_we;
    logic [PPN_W-1:0] wppn;

    // checker results
    logic             chk_leaf;
    logic             chk_fault;
    logic [31:0]      chk_paddr;
    logic             chk_need_wb;
    logic [31:0]      chk_pte_wb;

    walk_fsm walk_fsm_i (
        .CLK           (CLK),
        .i_arst_n      (i_arst_n),
        .i_req_valid   (i_req_valid),
        .o_req_ready   (o_req_ready),
        .i_req_vaddr   (i_req_vaddr),
        .i_req_acc     (i_req_acc),
        .i_priv        (i_priv),
        .i_satp        (i_satp),
        .i_sum         (i_sum),
        .i_mxr         (i_mxr),
        .o_rsp_valid   (o_rsp_valid),
        .i_rsp_ready   (i_rsp_ready),
        .o_rsp_paddr   (o_rsp_paddr),
        .o_rsp_fault   (o_rsp_fault),
        .o_rsp_cause   (o_rsp_cause),
        .o_mem_valid   (o_mem_valid),
        .i_mem_ready   (i_mem_ready),
        .o_mem_we      (o_mem_we),
        .o_mem_addr    (o_mem_addr),
        .o_mem_wdata   (o_mem_wdata),
        .i_mem_rvalid  (i_mem_rvalid),
        .i_mem_rdata   (i_mem_rdata),
        .i_code_hit    (code_hit),
        .i_code_ppn    (code_ppn),
        .i_read_hit    (read_hit),
        .i_read_ppn    (read_ppn),
        .i_write_hit   (write_hit),
        .i_write_ppn   (write_ppn),
        .i_chk_leaf    (chk_leaf),
        .i_chk_fault   (chk_fault),
        .i_chk_paddr   (chk_paddr),
        .i_chk_need_wb (chk_need_wb),
        .i_chk_pte_wb  (chk_pte_wb),
        .o_vaddr       (vaddr),
        .o_acc         (acc),
        .o_priv        (priv),
        .o_sum         (sum),
        .o_mxr         (mxr),
        .o_pte         (pte),
        .o_level       (level),
        .o_code_we     (code_we),
        .o_read_we     (read_we),
        .o_write_we    (write_we),
        .o_tlb_wppn    (wppn)
    );

    // one TLB per access kind, all indexed by the held VPN
    tlb #(.ENTRIES(TLB_ENTRIES)) tlb_code_i (
        .CLK      (CLK),
        .i_arst_n (i_arst_n),
        .i_flush  (i_flush),
        .i_we     (code_we),
        .i_vpn    (vaddr[31:PAGE_OFS_W]),
        .i_wppn   (wppn),
        .o_hit    (code_hit),
        .o_ppn    (code_ppn)
    );

    tlb #(.ENTRIES(TLB_ENTRIES)) tlb_read_i (
        .CLK      (CLK),
        .i_arst_n (i_arst_n),
        .i_flush  (i_flush),
        .i_we     (read_we),
        .i_vpn    (vaddr[31:PAGE_OFS_W]),
        .i_wppn   (wppn),
        .o_hit    (read_hit),
        .o_ppn    (read_ppn)
    );

    tlb #(.ENTRIES(TLB_ENTRIES)) tlb_write_i (
        .CLK      (CLK),
        .i_arst_n (i_arst_n),
        .i_flush  (i_flush),
        .i_we     (write_we),
        .i_vpn    (vaddr[31:PAGE_OFS_W]),
        .i_wppn   (wppn),
        .o_hit    (write_hit),
        .o_ppn    (write_ppn)
    );

    pte_check pte_check_i (
        .i_pte     (pte),
        .i_level   (level),
        .i_vaddr   (vaddr),
        .i_acc     (acc),
        .i_priv    (priv),
        .i_sum     (sum),
        .i_mxr     (mxr),
        .o_leaf    (chk_leaf),
        .o_fault   (chk_fault),
        .o_paddr   (chk_paddr),
        .o_need_wb (chk_need_wb),
        .o_pte_wb  (chk_pte_wb)
    );

endmodule

//--- test/mmu_sva.sv
/*
 * handshake assertions for walk_fsm
 *   response and memory command hold under back-pressure
 *   request ready never overlaps a pending response
 *   bare-mode requests issue no memory command
 */
`timescale 1ns/1ns

module mmu_sva (
    input logic        CLK,
    input logic        i_arst_n,
    input logic        i_req_valid,
    input logic        o_req_ready,
    input logic        bare,
    input logic        o_rsp_valid,
    input logic        i_rsp_ready,
    input logic [31:0] o_rsp_paddr,
    input logic        o_rsp_fault,
    input logic [3:0]  o_rsp_cause,
    input logic        o_mem_valid,
    input logic        i_mem_ready,
    input logic        o_mem_we,
    input logic [31:0] o_mem_addr,
    input logic [31:0] o_mem_wdata
);

    // stalled response keeps its data
    rsp_hold: assert property (@(posedge CLK) disable iff (!i_arst_n)
        o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp_paddr) &&
            $stable(o_rsp_fault) && $stable(o_rsp_cause))
        else $error("response changed while stalled");

    // write data only matters for write-backs
    mem_hold: assert property (@(posedge CLK) disable iff (!i_arst_n)
        o_mem_valid && !i_mem_ready |=> o_mem_valid && $stable(o_mem_we) &&
            $stable(o_mem_addr) && (!o_mem_we || $stable(o_mem_wdata)))
        else $error("memory command changed while stalled");

    ready_excl: assert property (@(posedge CLK) disable iff (!i_arst_n)
        !(o_req_ready && o_rsp_valid))
        else $error("request ready while a response is pending");

    bare_no_mem: assert property (@(posedge CLK) disable iff (!i_arst_n)
        i_req_valid && o_req_ready && bare |=> o_rsp_valid && !o_mem_valid)
        else $error("memory command in bare mode");

endmodule

//--- test/mmu_tb.sv
/*
 * testbench for mmu_top
 *   random page tables in a word memory with random read latency
 *   reference Sv32 walk, bare mode, random walks, TLB reuse and flush
 *   random response and memory back-pressure
 */
`timescale 1ns/1ns

module mmu_tb;
    import mmu_pkg::*;

    localparam int TIMEOUT_CYCLES = 300 * 60;

    logic        CLK;
    logic        i_arst_n;
    logic        i_req_valid;
    logic        o_req_ready;
    logic [31:0] i_req_vaddr;
    logic [1:0]  i_req_acc;
    logic [1:0]  i_priv;
    logic [31:0] i_satp;
    logic        i_sum;
    logic        i_mxr;
    logic        i_flush;
    logic        o_rsp_valid;
    logic        i_rsp_ready;
    logic [31:0] o_rsp_paddr;
    logic        o_rsp_fault;
    logic [3:0]  o_rsp_cause;
    logic        o_mem_valid;
    logic        i_mem_ready;
    logic        o_mem_we;
    logic [31:0] o_mem_addr;
    logic [31:0] o_mem_wdata;
    logic        i_mem_rvalid;
    logic [31:0] i_mem_rdata;

    // byte-addressed PTE memory
    logic [31:0] mem [logic [31:0]];
    logic [19:0] cur_root;
    logic [9:0]  vpn1_tab [8];
    logic [9:0]  vpn0_tab [8][8];
    logic [1:0]  ctx_priv;
    logic        ctx_sum;
    logic        ctx_mxr;

    logic        rd_pend;
    logic [31:0] rd_addr;
    int          rd_delay;
    int          n_reads;
    int          n_writes;
    int          n_acc;
    int          n_rsp;
    int          n_checks;
    int          n_errors;
    int          n_tests;
    int          n_failed;
    int          cycles;

    mmu_top #(.TLB_ENTRIES(4)) mmu_top_i (.*);

    bind walk_fsm mmu_sva mmu_sva_i (
        .CLK(CLK), .i_arst_n(i_arst_n), .i_req_valid(i_req_valid),
        .o_req_ready(o_req_ready), .bare(bare), .o_rsp_valid(o_rsp_valid),
        .i_rsp_ready(i_rsp_ready), .o_rsp_paddr(o_rsp_paddr), .o_rsp_fault(o_rsp_fault),
        .o_rsp_cause(o_rsp_cause), .o_mem_valid(o_mem_valid), .i_mem_ready(i_mem_ready),
        .o_mem_we(o_mem_we), .o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata)
    );

    always #50 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles++;
        if (o_rsp_valid && i_rsp_ready) begin
            n_rsp++;
        end
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] mem_read(input logic [31:0] a);
        return mem.exists(a) ? mem[a] : 32'd0;
    endfunction

    // memory model samples commands at the edge and answers after it
    always begin
        @(posedge CLK);
        if (i_arst_n) begin
            if (i_mem_rvalid) begin
                rd_pend = 1'b0;
            end
            if (o_mem_valid && i_mem_ready) begin
                if (o_mem_we) begin
                    mem[o_mem_addr] = o_mem_wdata;
                    n_writes++;
                end else begin
                    n_reads++;
                    if (!i_mem_rvalid) begin
                        rd_pend  = 1'b1;
                        rd_addr  = o_mem_addr;
                        rd_delay = $urandom % 4;
                    end
                end
            end
        end
        #5;
        i_mem_rvalid = 1'b0;
        i_mem_ready  = ($urandom % 3 != 0);
        if (rd_pend) begin
            if (rd_delay == 0) begin
                i_mem_rvalid = 1'b1;
                i_mem_rdata  = mem_read(rd_addr);
            end else begin
                rd_delay--;
            end
        end else if (o_mem_valid && !o_mem_we && i_mem_ready && $urandom % 4 == 0) begin
            // data in the same cycle as acceptance
            i_mem_rvalid = 1'b1;
            i_mem_rdata  = mem_read(o_mem_addr);
        end
        i_rsp_ready = ($urandom % 4 != 0);
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        assert (got === exp) else begin
            $display("ERR %s got %h exp %h", name, got, exp);
            n_errors++;
        end
    endtask

    function automatic logic [31:0] rand_leaf();
        logic [2:0] xwr;
        logic       v;
        xwr = 3'($urandom);
        v   = ($urandom % 8 != 0);
        return {22'($urandom), 2'b00, 1'($urandom), 1'($urandom), 1'b0, 1'($urandom), xwr, v};
    endfunction

    task automatic build_tables();
        logic [31:0] a;
        logic [19:0] tbl;
        int          kind;
        mem.delete();
        cur_root = 20'h00040 | 20'($urandom % 16);
        for (int i = 0; i < 8; i++) begin
            vpn1_tab[i] = {3'(i), 7'($urandom)};
            a    = {cur_root, vpn1_tab[i], 2'b00};
            kind = $urandom % 8;
            for (int j = 0; j < 8; j++) begin
                vpn0_tab[i][j] = {3'(j), 7'($urandom)};
            end
            if (kind == 0) begin
                mem[a] = rand_leaf() & ~32'd1;
            end else if (kind < 3) begin
                // megapage with PPN0 zero
                mem[a] = rand_leaf() & 32'hFFF0_03FF;
            end else begin
                tbl    = 20'h00100 + 20'(i);
                mem[a] = {2'b00, tbl, 10'h001};
                for (int j = 0; j < 8; j++) begin
                    mem[{tbl, vpn0_tab[i][j], 2'b00}] = rand_leaf();
                end
            end
        end
    endtask

    function automatic logic [31:0] pick_va();
        int         i;
        logic [9:0] vpn0;
        i    = $urandom % 8;
        vpn0 = ($urandom % 6 == 0) ? 10'($urandom) : vpn0_tab[i][$urandom % 8];
        return {vpn1_tab[i], vpn0, 12'($urandom)};
    endfunction

    // reference Sv32 walk on the current memory contents
    task automatic model_walk(input logic [31:0] va, input logic [1:0] acc,
                              output logic [31:0] pa, output logic flt,
                              output logic [3:0] cause, output logic wb,
                              output logic [31:0] pte_addr, output logic [31:0] pte_new);
        logic [31:0] pte;
        logic        lvl;
        logic        leaf;
        logic        perm;
        logic        done;
        lvl      = 1'b1;
        done     = 1'b0;
        flt      = 1'b0;
        pa       = 32'd0;
        pte      = 32'd0;
        pte_addr = {cur_root, va[31:22], 2'b00};
        for (int step = 0; step < 2 && !done; step++) begin
            pte  = mem_read(pte_addr);
            leaf = pte[1] | pte[2] | pte[3];
            if (!pte[0]) begin
                flt  = 1'b1;
                done = 1'b1;
            end else if (!leaf) begin
                if (!lvl) begin
                    flt  = 1'b1;
                    done = 1'b1;
                end else begin
                    pte_addr = {pte[29:10], va[21:12], 2'b00};
                    lvl      = 1'b0;
                end
            end else begin
                done = 1'b1;
                case (acc)
                    ACC_READ:  perm = pte[1] | (ctx_mxr & pte[3]);
                    ACC_WRITE: perm = pte[2];
                    default:   perm = pte[3];
                endcase
                flt = (pte[2] && !pte[1]) || !perm ||
                      (ctx_priv == PRIV_S && pte[4] && !ctx_sum) ||
                      (ctx_priv == PRIV_U && !pte[4]);
                pa  = lvl ? {pte[29:20], va[21:0]} : {pte[29:10], va[11:0]};
            end
        end
        if (flt) begin
            pa = 32'd0;
        end
        cause   = !flt ? 4'd0 : (acc == ACC_CODE) ? 4'd12 : (acc == ACC_READ) ? 4'd13 : 4'd15;
        wb      = !flt && (!pte[6] || (acc == ACC_WRITE && !pte[7]));
        pte_new = pte | 32'h40 | ((acc == ACC_WRITE) ? 32'h80 : 32'h0);
    endtask

    task automatic issue_req(input logic [31:0] va, input logic [1:0] acc,
                             input logic [1:0] priv, input logic [31:0] satp,
                             output logic [31:0] pa, output logic flt, output logic [3:0] cause);
        @(posedge CLK);
        #5;
        n_reads      = 0;
        n_writes     = 0;
        i_req_valid  = 1'b1;
        i_req_vaddr  = va;
        i_req_acc    = acc;
        i_priv       = priv;
        i_satp       = satp;
        i_sum        = ctx_sum;
        i_mxr        = ctx_mxr;
        do @(posedge CLK); while (!o_req_ready);
        n_acc++;
        #5;
        i_req_valid = 1'b0;
        do @(posedge CLK); while (!(o_rsp_valid && i_rsp_ready));
        pa    = o_rsp_paddr;
        flt   = o_rsp_fault;
        cause = o_rsp_cause;
    endtask

    task automatic flush_tlbs();
        @(posedge CLK);
        #5;
        i_flush = 1'b1;
        @(posedge CLK);
        #5;
        i_flush = 1'b0;
    endtask

    task automatic run_paged(input logic [31:0] va, input logic [1:0] acc);
        logic [31:0] exp_pa;
        logic [31:0] got_pa;
        logic [31:0] pte_addr;
        logic [31:0] pte_new;
        logic [31:0] pte_old;
        logic [3:0]  exp_c;
        logic [3:0]  got_c;
        logic        exp_f;
        logic        got_f;
        logic        wb;
        model_walk(va, acc, exp_pa, exp_f, exp_c, wb, pte_addr, pte_new);
        pte_old = mem_read(pte_addr);
        issue_req(va, acc, ctx_priv, {1'b1, 11'd0, cur_root}, got_pa, got_f, got_c);
        check("o_rsp_fault", got_f, exp_f);
        check("o_rsp_paddr", got_pa, exp_pa);
        if (exp_f) begin
            check("o_rsp_cause", got_c, exp_c);
        end
        check("mem_writes", n_writes, wb);
        check("pte", mem_read(pte_addr), exp_f ? pte_old : pte_new);
    endtask

    task automatic finish_test(input string name, input int err_before);
        n_tests++;
        if (n_errors == err_before) begin
            $display("test %s ok", name);
        end else begin
            n_failed++;
            $display("test %s fail with %0d errors", name, n_errors - err_before);
        end
    endtask

    task automatic test_bare();
        logic [31:0] va;
        logic [31:0] pa;
        logic [3:0]  c;
        logic [1:0]  priv;
        logic        f;
        int          e0;
        e0 = n_errors;
        for (int k = 0; k < 40; k++) begin
            va   = $urandom;
            priv = ($urandom % 2) ? PRIV_M : 2'($urandom % 2);
            issue_req(va, 2'($urandom % 3), priv,
                      {(priv == PRIV_M) ? 1'($urandom) : 1'b0, 31'($urandom)}, pa, f, c);
            check("o_rsp_paddr", pa, va);
            check("o_rsp_fault", f, 0);
            check("mem_commands", n_reads + n_writes, 0);
        end
        finish_test("bare_mode", e0);
    endtask

    task automatic test_random();
        int e0;
        e0 = n_errors;
        for (int g = 0; g < 10; g++) begin
            // a new context needs empty TLBs
            ctx_priv = ($urandom % 2) ? PRIV_S : PRIV_U;
            ctx_sum  = 1'($urandom);
            ctx_mxr  = 1'($urandom);
            flush_tlbs();
            for (int k = 0; k < 20; k++) begin
                run_paged(pick_va(), 2'($urandom % 3));
            end
        end
        finish_test("random_walk", e0);
    endtask

    task automatic test_tlb_reuse();
        logic [31:0] va;
        logic [31:0] pa;
        logic [31:0] pa_addr;
        logic [31:0] pte_new;
        logic [3:0]  c;
        logic [1:0]  acc;
        logic        f;
        logic        wb;
        logic        found;
        int          e0;
        e0       = n_errors;
        found    = 1'b0;
        ctx_priv = PRIV_S;
        ctx_sum  = 1'b1;
        ctx_mxr  = 1'b1;
        for (int k = 0; k < 500 && !found; k++) begin
            va  = pick_va();
            acc = 2'($urandom % 3);
            model_walk(va, acc, pa, f, c, wb, pa_addr, pte_new);
            found = !f;
        end
        if (!found) begin
            $display("tlb_reuse: no mapping without a fault was found");
            n_errors++;
        end else begin
            flush_tlbs();
            run_paged(va, acc);
            check("walk_reads", n_reads != 0, 1);
            run_paged(va, acc);
            check("hit_reads", n_reads, 0);
            flush_tlbs();
            run_paged(va, acc);
            check("flush_reads", n_reads != 0, 1);
        end
        finish_test("tlb_reuse", e0);
    endtask

    initial begin
        void'($urandom(20844));
        CLK          = 1'b0;
        i_arst_n     = 1'b0;
        i_req_valid  = 1'b0;
        i_req_vaddr  = '0;
        i_req_acc    = '0;
        i_priv       = PRIV_M;
        i_satp       = '0;
        i_sum        = 1'b0;
        i_mxr        = 1'b0;
        i_flush      = 1'b0;
        i_rsp_ready  = 1'b1;
        i_mem_ready  = 1'b0;
        i_mem_rvalid = 1'b0;
        i_mem_rdata  = '0;
        rd_pend      = 1'b0;
        ctx_priv     = PRIV_S;
        ctx_sum      = 1'b0;
        ctx_mxr      = 1'b0;
        build_tables();
        repeat (2) @(posedge CLK);
        #5;
        i_arst_n = 1'b1;

        test_bare();
        test_random();
        test_tlb_reuse();

        repeat (2) @(posedge CLK);
        check("responses", n_rsp, n_acc);
        $display("tests %0d failed %0d checks %0d errors %0d",
                 n_tests, n_failed, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
rtl/mmu_pkg.sv
rtl/tlb.sv
rtl/pte_check.sv
rtl/walk_fsm.sv
rtl/mmu_top.sv
test/mmu_sva.sv
test/mmu_tb.sv

//--- Bender.yml
package:
  name: mmu

sources:
  - rtl/mmu_pkg.sv
  - rtl/tlb.sv
  - rtl/pte_check.sv
  - rtl/walk_fsm.sv
  - rtl/mmu_top.sv
  - target: test
    files:
      - test/mmu_sva.sv
      - test/mmu_tb.sv
